// File: common/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// bus address width
`define ADDR_W 32

// bus data width, one 64-bit word per beat
`define DATA_W 64

// one strobe bit per data byte
`define STRB_W 8

// word index, 1024 words of 8 bytes
`define MEM_IDX_W 10

// start of the sram window, 8 KiB long
`define MEM_BASE 32'h8000_0000

`endif

// File: common/axi_pkg.sv
package axi_pkg;

	// response codes on rresp and bresp
	// exokay and decerr never produced here
	typedef enum logic [1:0] {
		resp_okay   = 2'd0,
		resp_slverr = 2'd2
	} axi_resp_e;

	// slave read channel
	// rd_idle waits for arvalid, rd_resp holds rvalid
	typedef enum logic {
		rd_idle,
		rd_resp
	} rd_state_e;

	// slave write channel
	// wr_idle waits for awvalid and wvalid together
	// wr_resp holds bvalid until bready
	typedef enum logic {
		wr_idle,
		wr_resp
	} wr_state_e;

endpackage

// File: common/lsu_pkg.sv
package lsu_pkg;

	// request opcode
	// load_u zero extends, load_s sign extends
	typedef enum logic [1:0] {
		op_load_u,
		op_load_s,
		op_store
	} lsu_op_e;

	// access size, encoded as log2 of the byte count
	typedef enum logic [1:0] {
		size_b,
		size_h,
		size_w,
		size_d
	} lsu_size_e;

	// master sequencing
	typedef enum logic [1:0] {
		lsu_idle,
		lsu_rd,
		lsu_wr,
		lsu_done
	} lsu_state_e;

endpackage

// File: sram/sram_array.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module sram_array (
	input  logic                  clk,
	// read port, data one cycle after rd_en
	input  logic                  rd_en,
	input  logic [`MEM_IDX_W-1:0] rd_idx,
	output logic [`DATA_W-1:0]    rd_data,
	// byte masked write port
	input  logic                  wr_en,
	input  logic [`MEM_IDX_W-1:0] wr_idx,
	input  logic [`DATA_W-1:0]    wr_data,
	input  logic [`STRB_W-1:0]    wr_strb
);

	// word organized storage
	logic [`DATA_W-1:0] mem [0:(1 << `MEM_IDX_W)-1];

	// registered read, output held while rd_en low
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_idx];
		end
	end

	// only strobed bytes change
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < `STRB_W; i++) begin
				if (wr_strb[i]) begin
					mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
				end
			end
		end
	end

	// a write with no bytes selected means the master built a bad strobe
	a_wr_strb_nonzero: assert property (
		@(posedge clk) wr_en |-> (wr_strb != '0)
	) else $error("sram_array: write enabled with empty strobe");

endmodule

// File: sram/sram_axi_slave.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module sram_axi_slave (
	input  logic                  clk,
	input  logic                  rst,
	// read address channel
	input  logic                  arvalid,
	input  logic [`ADDR_W-1:0]    araddr,
	output logic                  arready,
	// read data channel
	output logic                  rvalid,
	output logic [`DATA_W-1:0]    rdata,
	output axi_pkg::axi_resp_e    rresp,
	input  logic                  rready,
	// write address channel
	input  logic                  awvalid,
	input  logic [`ADDR_W-1:0]    awaddr,
	output logic                  awready,
	// write data channel
	input  logic                  wvalid,
	input  logic [`DATA_W-1:0]    wdata,
	input  logic [`STRB_W-1:0]    wstrb,
	output logic                  wready,
	// write response channel
	output logic                  bvalid,
	output axi_pkg::axi_resp_e    bresp,
	input  logic                  bready,
	// storage array
	output logic                  rd_en,
	output logic [`MEM_IDX_W-1:0] rd_idx,
	input  logic [`DATA_W-1:0]    rd_data,
	output logic                  wr_en,
	output logic [`MEM_IDX_W-1:0] wr_idx,
	output logic [`DATA_W-1:0]    wr_data,
	output logic [`STRB_W-1:0]    wr_strb
);
	import axi_pkg::*;

	rd_state_e rd_state;
	wr_state_e wr_state;
	logic      ar_hs;
	logic      wr_hs;
	// set when the accepted address fell outside the window
	logic      rd_err;
	logic      wr_err;

	// address lies in [MEM_BASE, MEM_BASE + 8 KiB)
	// below-base addresses wrap to a large offset
	function automatic logic in_window(input logic [`ADDR_W-1:0] a);
		logic [`ADDR_W-1:0] off;
		off = a - `MEM_BASE;
		return off < `ADDR_W'(`STRB_W << `MEM_IDX_W);
	endfunction

	// read side
	assign arready = (rd_state == rd_idle);
	assign ar_hs   = arvalid && arready;
	// array only touched for in-window reads
	assign rd_en   = ar_hs && in_window(araddr);
	assign rd_idx  = araddr[$clog2(`STRB_W) +: `MEM_IDX_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= rd_idle;
		end else begin
			case (rd_state)
				rd_idle: if (ar_hs) rd_state <= rd_resp;
				rd_resp: if (rready) rd_state <= rd_idle;
				default: rd_state <= rd_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rd_err <= !in_window(araddr);
		end
	end

	// array output stays stable through rd_resp since rd_en is low there
	assign rvalid = (rd_state == rd_resp);
	assign rdata  = rd_err ? '0 : rd_data;
	assign rresp  = rd_err ? resp_slverr : resp_okay;

	// write side, address and data taken in the same cycle
	assign awready = (wr_state == wr_idle);
	assign wready  = (wr_state == wr_idle);
	assign wr_hs   = awvalid && wvalid && (wr_state == wr_idle);
	assign wr_en   = wr_hs && in_window(awaddr);
	assign wr_idx  = awaddr[$clog2(`STRB_W) +: `MEM_IDX_W];
	assign wr_data = wdata;
	assign wr_strb = wstrb;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= wr_idle;
		end else begin
			case (wr_state)
				wr_idle: if (wr_hs) wr_state <= wr_resp;
				wr_resp: if (bready) wr_state <= wr_idle;
				default: wr_state <= wr_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			wr_err <= !in_window(awaddr);
		end
	end

	assign bvalid = (wr_state == wr_resp);
	assign bresp  = wr_err ? resp_slverr : resp_okay;

	// responses and their payload are held until the master takes them
	a_rvalid_hold: assert property (
		@(posedge clk) disable iff (rst)
			rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
	) else $error("sram_axi_slave: read response changed before rready");

	a_bvalid_hold: assert property (
		@(posedge clk) disable iff (rst)
			bvalid && !bready |=> bvalid && $stable(bresp)
	) else $error("sram_axi_slave: write response changed before bready");

	// aw and w always complete in the same cycle
	a_aw_w_together: assert property (
		@(posedge clk) disable iff (rst) (awvalid && awready) == (wvalid && wready)
	) else $error("sram_axi_slave: aw and w accepted apart");

endmodule

// File: hw/lsu_axi_master.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module lsu_axi_master (
	input  logic                clk,
	input  logic                rst,
	// request side, single cycle strobe
	input  logic                req,
	input  lsu_pkg::lsu_op_e    op,
	input  lsu_pkg::lsu_size_e  size,
	input  logic [`ADDR_W-1:0]  addr,
	input  logic [`DATA_W-1:0]  wdata,
	output logic                done,
	output logic [`DATA_W-1:0]  rdata,
	output logic                err,
	// bus side
	output logic                arvalid,
	output logic [`ADDR_W-1:0]  araddr,
	input  logic                arready,
	input  logic                rvalid,
	input  logic [`DATA_W-1:0]  bus_rdata,
	input  axi_pkg::axi_resp_e  rresp,
	output logic                rready,
	output logic                awvalid,
	output logic [`ADDR_W-1:0]  awaddr,
	input  logic                awready,
	output logic                wvalid,
	output logic [`DATA_W-1:0]  bus_wdata,
	output logic [`STRB_W-1:0]  wstrb,
	input  logic                wready,
	input  logic                bvalid,
	input  axi_pkg::axi_resp_e  bresp,
	output logic                bready
);
	import lsu_pkg::*;
	import axi_pkg::*;

	lsu_state_e         state;
	logic               accept;
	logic               misaligned;
	// byte offset inside the 8-byte word
	logic [2:0]         off;
	logic [`STRB_W-1:0] size_mask;
	// request fields kept for load extraction
	lsu_op_e            op_q;
	lsu_size_e          size_q;
	logic [2:0]         off_q;
	logic [`DATA_W-1:0] lane;
	logic [`DATA_W-1:0] load_val;
	logic               sx;

	// the done cycle already counts as ready for the next request
	assign accept = req && (state == lsu_idle || state == lsu_done);
	assign off    = addr[2:0];
	assign done   = (state == lsu_done);
	assign rready = (state == lsu_rd);
	assign bready = (state == lsu_wr);

	// alignment and unshifted strobe per size
	always_comb begin
		case (size)
			size_b: begin
				misaligned = 1'b0;
				size_mask  = 8'h01;
			end
			size_h: begin
				misaligned = off[0];
				size_mask  = 8'h03;
			end
			size_w: begin
				misaligned = (off[1:0] != 2'b00);
				size_mask  = 8'h0f;
			end
			default: begin
				misaligned = (off != 3'b000);
				size_mask  = 8'hff;
			end
		endcase
	end

	// control, misaligned requests skip the bus entirely
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= lsu_idle;
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else begin
			case (state)
				lsu_idle, lsu_done: begin
					if (!accept) begin
						state <= lsu_idle;
					end else if (misaligned) begin
						state <= lsu_done;
					end else if (op == op_store) begin
						state   <= lsu_wr;
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
					end else begin
						state   <= lsu_rd;
						arvalid <= 1'b1;
					end
				end
				lsu_rd: begin
					if (arready) arvalid <= 1'b0;
					if (rvalid) state <= lsu_done;
				end
				lsu_wr: begin
					// each valid drops on its own handshake
					if (awready) awvalid <= 1'b0;
					if (wready) wvalid <= 1'b0;
					if (bvalid) state <= lsu_done;
				end
				default: state <= lsu_idle;
			endcase
		end
	end

	// bus payload, word aligned address and store data moved into its lane
	always_ff @(posedge clk) begin
		if (accept) begin
			araddr    <= {addr[`ADDR_W-1:3], 3'b000};
			awaddr    <= {addr[`ADDR_W-1:3], 3'b000};
			bus_wdata <= wdata << {off, 3'b000};
			wstrb     <= size_mask << off;
			op_q      <= op;
			size_q    <= size;
			off_q     <= off;
		end
		// result, only meaningful while done
		if (accept && misaligned) begin
			rdata <= '0;
			err   <= 1'b1;
		end else if (state == lsu_rd && rvalid) begin
			rdata <= load_val;
			err   <= (rresp == resp_slverr);
		end else if (state == lsu_wr && bvalid) begin
			rdata <= '0;
			err   <= (bresp == resp_slverr);
		end
	end

	// pick the addressed lane, then zero or sign extend
	always_comb begin
		lane     = bus_rdata >> {off_q, 3'b000};
		sx       = 1'b0;
		load_val = lane;
		case (size_q)
			size_b: begin
				sx       = (op_q == op_load_s) && lane[7];
				load_val = {{(`DATA_W-8){sx}}, lane[7:0]};
			end
			size_h: begin
				sx       = (op_q == op_load_s) && lane[15];
				load_val = {{(`DATA_W-16){sx}}, lane[15:0]};
			end
			size_w: begin
				sx       = (op_q == op_load_s) && lane[31];
				load_val = {{(`DATA_W-32){sx}}, lane[31:0]};
			end
			default: load_val = lane;
		endcase
	end

	// one access at a time, no request while a transaction runs
	a_req_when_free: assert property (
		@(posedge clk) disable iff (rst) req |-> (state == lsu_idle || state == lsu_done)
	) else $error("lsu_axi_master: request while busy");

endmodule

// File: hw/mem_subsys_top.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               req,
	input  lsu_pkg::lsu_op_e   op,
	input  lsu_pkg::lsu_size_e size,
	input  logic [`ADDR_W-1:0] addr,
	input  logic [`DATA_W-1:0] wdata,
	output logic               done,
	output logic [`DATA_W-1:0] rdata,
	output logic               err
);
	import axi_pkg::*;

	// bus between master and slave
	logic                  arvalid;
	logic [`ADDR_W-1:0]    araddr;
	logic                  arready;
	logic                  rvalid;
	logic [`DATA_W-1:0]    bus_rdata;
	axi_resp_e             rresp;
	logic                  rready;
	logic                  awvalid;
	logic [`ADDR_W-1:0]    awaddr;
	logic                  awready;
	logic                  wvalid;
	logic [`DATA_W-1:0]    bus_wdata;
	logic [`STRB_W-1:0]    wstrb;
	logic                  wready;
	logic                  bvalid;
	axi_resp_e             bresp;
	logic                  bready;
	// slave to array
	logic                  rd_en;
	logic [`MEM_IDX_W-1:0] rd_idx;
	logic [`DATA_W-1:0]    rd_data;
	logic                  wr_en;
	logic [`MEM_IDX_W-1:0] wr_idx;
	logic [`DATA_W-1:0]    wr_data;
	logic [`STRB_W-1:0]    wr_strb;

	lsu_axi_master lsu_axi_master_i (.*);

	// slave data ports carry the bus data, not the request data
	sram_axi_slave sram_axi_slave_i (
		.rdata (bus_rdata),
		.wdata (bus_wdata),
		.*
	);

	sram_array sram_array_i (.*);

endmodule

// File: verif/tb_mem_subsys.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_mem_subsys;
	import lsu_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int N_ROWS       = 31;
	// an aligned access needs three cycles, so twenty per row is plenty
	localparam int WATCHDOG_CYCLES = N_ROWS * 20 + RESET_CYCLES;
	localparam logic [`ADDR_W-1:0] BASE = `MEM_BASE;

	logic               clk;
	logic               rst;
	logic               req;
	lsu_op_e            op;
	lsu_size_e          size;
	logic [`ADDR_W-1:0] addr;
	logic [`DATA_W-1:0] wdata;
	logic               done;
	logic [`DATA_W-1:0] rdata;
	logic               err;

	// stimulus and expected results, one entry per access
	lsu_op_e            t_op    [N_ROWS];
	lsu_size_e          t_size  [N_ROWS];
	logic [`ADDR_W-1:0] t_addr  [N_ROWS];
	logic [`DATA_W-1:0] t_wdata [N_ROWS];
	logic [`DATA_W-1:0] t_rdata [N_ROWS];
	logic               t_err   [N_ROWS];
	string              t_name  [N_ROWS];
	int                 n_rows;
	int                 latency;
	int                 exp_lat;

	mem_subsys_top mem_subsys_top_i (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.op    (op),
		.size  (size),
		.addr  (addr),
		.wdata (wdata),
		.done  (done),
		.rdata (rdata),
		.err   (err)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic add_row(input lsu_op_e o, input lsu_size_e s, input logic [`ADDR_W-1:0] a,
		input logic [`DATA_W-1:0] wd, input logic [`DATA_W-1:0] rd, input logic e,
		input string name);
		t_op[n_rows]    = o;
		t_size[n_rows]  = s;
		t_addr[n_rows]  = a;
		t_wdata[n_rows] = wd;
		t_rdata[n_rows] = rd;
		t_err[n_rows]   = e;
		t_name[n_rows]  = name;
		n_rows++;
	endtask

	// one cycle when the address is not a multiple of the size, else three
	function automatic int expect_latency(input lsu_size_e s, input logic [`ADDR_W-1:0] a);
		logic [`ADDR_W-1:0] nbytes;
		nbytes = 32'd1 << s;
		if ((a % nbytes) != 32'd0) begin
			return 1;
		end
		return 3;
	endfunction

	task automatic fill_table();
		// full word round trip
		add_row(op_store,  size_d, BASE + 32'h000, 64'h0123_4567_89ab_cdef, '0, 1'b0, "st_d_w0");
		add_row(op_load_u, size_d, BASE + 32'h000, '0, 64'h0123_4567_89ab_cdef, 1'b0, "ld_d_w0");
		// sub-word stores merge into their lanes only
		add_row(op_store,  size_d, BASE + 32'h008, 64'h1111_2222_3333_4444, '0, 1'b0, "st_d_w1");
		// 55 lands in byte 4 on the bus but its strobe is off
		add_row(op_store,  size_b, BASE + 32'h00b, 64'h0000_0000_0000_55aa, '0, 1'b0, "st_b_w1");
		add_row(op_store,  size_h, BASE + 32'h00c, 64'h0000_0000_0000_beef, '0, 1'b0, "st_h_w1");
		add_row(op_load_u, size_d, BASE + 32'h008, '0, 64'h1111_beef_aa33_4444, 1'b0, "ld_merged_w1");
		add_row(op_store,  size_d, BASE + 32'h010, 64'h0, '0, 1'b0, "st_d_w2");
		add_row(op_store,  size_w, BASE + 32'h014, 64'h0000_0000_dead_beef, '0, 1'b0, "st_w_w2");
		add_row(op_load_u, size_d, BASE + 32'h010, '0, 64'hdead_beef_0000_0000, 1'b0, "ld_merged_w2");
		// zero and sign extension, bytes c3 d2 e1 f0 21 43 65 87
		add_row(op_store,  size_d, BASE + 32'h018, 64'h8765_4321_f0e1_d2c3, '0, 1'b0, "st_d_w3");
		add_row(op_load_u, size_b, BASE + 32'h018, '0, 64'h0000_0000_0000_00c3, 1'b0, "ld_bu_neg");
		add_row(op_load_s, size_b, BASE + 32'h018, '0, 64'hffff_ffff_ffff_ffc3, 1'b0, "ld_bs_neg");
		add_row(op_load_s, size_b, BASE + 32'h01c, '0, 64'h0000_0000_0000_0021, 1'b0, "ld_bs_pos");
		add_row(op_load_u, size_h, BASE + 32'h01a, '0, 64'h0000_0000_0000_f0e1, 1'b0, "ld_hu_neg");
		add_row(op_load_s, size_h, BASE + 32'h01a, '0, 64'hffff_ffff_ffff_f0e1, 1'b0, "ld_hs_neg");
		add_row(op_load_u, size_w, BASE + 32'h018, '0, 64'h0000_0000_f0e1_d2c3, 1'b0, "ld_wu_neg");
		add_row(op_load_s, size_w, BASE + 32'h018, '0, 64'hffff_ffff_f0e1_d2c3, 1'b0, "ld_ws_lo");
		add_row(op_load_s, size_w, BASE + 32'h01c, '0, 64'hffff_ffff_8765_4321, 1'b0, "ld_ws_hi");
		add_row(op_load_s, size_d, BASE + 32'h018, '0, 64'h8765_4321_f0e1_d2c3, 1'b0, "ld_ds_w3");
		// misaligned, no bus traffic and memory untouched
		add_row(op_store,  size_h, BASE + 32'h001, 64'h0000_0000_0000_ffff, '0, 1'b1, "st_h_misal");
		add_row(op_store,  size_w, BASE + 32'h002, 64'h0000_0000_ffff_ffff, '0, 1'b1, "st_w_misal");
		add_row(op_load_s, size_h, BASE + 32'h003, '0, 64'h0, 1'b1, "ld_h_misal");
		add_row(op_store,  size_d, BASE + 32'h004, 64'hffff_ffff_ffff_ffff, '0, 1'b1, "st_d_misal");
		add_row(op_load_u, size_d, BASE + 32'h000, '0, 64'h0123_4567_89ab_cdef, 1'b0, "ld_after_misal");
		// last word of the window is still inside
		add_row(op_store,  size_d, BASE + 32'h1ff8, 64'hcafe_f00d_1234_5678, '0, 1'b0, "st_d_top");
		add_row(op_load_u, size_d, BASE + 32'h1ff8, '0, 64'hcafe_f00d_1234_5678, 1'b0, "ld_d_top");
		// outside the window, 0x2000 would alias word 0 if decoded wrong
		add_row(op_store,  size_d, BASE + 32'h2000, 64'hffff_ffff_ffff_ffff, '0, 1'b1, "st_d_above");
		add_row(op_load_u, size_d, BASE + 32'h2000, '0, 64'h0, 1'b1, "ld_d_above");
		add_row(op_load_u, size_w, BASE - 32'h8, '0, 64'h0, 1'b1, "ld_w_below");
		add_row(op_store,  size_b, 32'h0000_0000, 64'h0000_0000_0000_0077, '0, 1'b1, "st_b_zero");
		add_row(op_load_u, size_d, BASE + 32'h000, '0, 64'h0123_4567_89ab_cdef, 1'b0, "ld_after_oow");
	endtask

	// watchdog for a done that never comes
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: done did not arrive within %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		clk    = 1'b0;
		rst    = 1'b1;
		req    = 1'b0;
		op     = op_load_u;
		size   = size_b;
		addr   = '0;
		wdata  = '0;
		n_rows = 0;
		fill_table();

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int i = 0; i < n_rows; i++) begin
			// drive just after the edge, req high for one cycle
			op    = t_op[i];
			size  = t_size[i];
			addr  = t_addr[i];
			wdata = t_wdata[i];
			req   = 1'b1;
			// count edges from driving req until done is seen
			latency = 0;
			do begin
				@(posedge clk);
				#1;
				req = 1'b0;
				latency++;
			end while (done !== 1'b1);

			assert (err === t_err[i]) else begin
				$display("ERR %s err expected %0b actual %0b", t_name[i], t_err[i], err);
				abort_run();
			end
			// a store only defines rdata on error, where it reads zero
			if (t_op[i] != op_store || t_err[i]) begin
				assert (rdata === t_rdata[i]) else begin
					$display("ERR %s rdata expected %h actual %h", t_name[i], t_rdata[i], rdata);
					abort_run();
				end
			end
			exp_lat = expect_latency(t_size[i], t_addr[i]);
			assert (latency == exp_lat) else begin
				$display("ERR %s latency expected %0d actual %0d", t_name[i], exp_lat, latency);
				abort_run();
			end
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: sources.f
+incdir+common
common/axi_pkg.sv
common/lsu_pkg.sv
sram/sram_array.sv
sram/sram_axi_slave.sv
hw/lsu_axi_master.sv
hw/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// File: Makefile
TOP := tb_mem_subsys

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f sources.f \
		--top-module mem_subsys_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
